//--- bench/meta_predictor_tb.sv
module meta_predictor_tb;

  localparam int half_period = 5;
  localparam int reset_cycles = 5;
  localparam string data_path = "bench/meta_predictor_testdata.txt";

  logic clk = 1'b0;
  logic rst_n;
  bp_types_pkg::lookup_t   lookup;
  bp_types_pkg::resolve_t  resolve;
  logic                    prediction;
  bp_types_pkg::provider_t provider;

  // one entry per data line
  bp_types_pkg::lookup_t  lookup_q[$];
  bp_types_pkg::resolve_t resolve_q[$];
  logic                   pred_q[$];
  logic [1:0]             prov_q[$];
  int                     line_q[$];

  logic loaded = 1'b0;
  int   cur_line = 0;

  always #(half_period) clk = ~clk;

  meta_predictor u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .lookup     (lookup),
    .resolve    (resolve),
    .prediction (prediction),
    .provider   (provider)
  );

  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic compare_value(string name, logic [31:0] actual, logic [31:0] expected);
    if (actual !== expected)
      stop_with_failure($sformatf("Mismatch at time %0t: %s is %0h, expected %0h (data line %0d)",
                                  $time, name, actual, expected, cur_line));
  endtask

  task automatic load_vectors();
    int fd;
    int n;
    int line_no;
    string text;
    logic [11:0] v [12];
    bp_types_pkg::lookup_t lk;
    bp_types_pkg::resolve_t rs;
    fd = $fopen(data_path, "r");
    if (fd == 0)
      stop_with_failure($sformatf("could not open data file %s", data_path));
    else
    begin
      line_no = 0;
      while ($fgets(text, fd) > 0)
      begin
        line_no++;
        // skip comments and empty lines
        if (text.len() > 0 && text[0] != "#" && text[0] != "\n")
        begin
          n = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h",
                      v[0], v[1], v[2], v[3], v[4], v[5],
                      v[6], v[7], v[8], v[9], v[10], v[11]);
          if (n != 12)
            stop_with_failure($sformatf("data line %0d does not hold 12 fields", line_no));
          else
          begin
            lk.branch_type = v[0][5:0];
            lk.sp_taken    = v[1][0];
            lk.ghp_count   = v[2][1:0];
            lk.lhp_counts  = v[3][11:0];
            rs.valid       = v[4][0];
            rs.taken       = v[5][0];
            rs.branch_type = v[6][5:0];
            rs.sp_taken    = v[7][0];
            rs.ghp_count   = v[8][1:0];
            rs.lhp_counts  = v[9][11:0];
            lookup_q.push_back(lk);
            resolve_q.push_back(rs);
            pred_q.push_back(v[10][0]);
            prov_q.push_back(v[11][1:0]);
            line_q.push_back(line_no);
          end
        end
      end
      $fclose(fd);
      if (lookup_q.size() == 0)
        stop_with_failure("data file holds no test vectors");
    end
  endtask

  initial
  begin
    rst_n = 1'b0;
    lookup = '0;
    resolve = '0;
    load_vectors();
    loaded = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    for (int i = 0; i < lookup_q.size(); i++)
    begin
      @(negedge clk);
      lookup = lookup_q[i];
      resolve = resolve_q[i];
      cur_line = line_q[i];
      // sample just before the write edge
      #(half_period - 1);
      compare_value("prediction", 32'(prediction), 32'(pred_q[i]));
      compare_value("provider", 32'(provider), 32'(prov_q[i]));
    end
    $display("TEST PASS");
    $finish;
  end

  // one clock period per vector, margin covers reset
  initial
  begin
    int limit;
    wait (loaded);
    limit = lookup_q.size() * 10 + 200;
    #(limit);
    stop_with_failure($sformatf("watchdog expired after %0d time units", limit));
  end

endmodule

//--- bench/meta_predictor_testdata.txt
# lk_type lk_sp lk_ghp lk_lhp rs_valid rs_taken rs_type rs_sp rs_ghp rs_lhp exp_pred exp_prov
# hex fields; lhp holds six 2-bit counters with beq on top; provider 0 sp, 1 lhp, 2 ghp
# after reset every type follows the static predictor
20 1 0 000 0 0 00 0 0 000 1 0
10 0 3 000 0 0 00 0 0 000 0 0
08 1 2 fff 0 0 00 0 0 000 1 0
04 0 1 555 0 0 00 0 0 000 0 0
02 1 0 aaa 0 0 00 0 0 000 1 0
01 0 3 fff 0 0 00 0 0 000 0 0
# beq: sp wrong and ghp right until ghp takes over
20 1 0 c00 1 0 20 1 0 c00 1 0
20 1 0 c00 1 0 20 1 0 c00 1 0
20 1 0 c00 1 0 20 1 0 c00 1 0
20 1 0 c00 1 0 20 1 0 c00 1 0
20 1 0 c00 1 0 20 1 0 c00 0 2
20 1 0 c00 0 0 00 0 0 000 0 2
10 0 0 000 0 0 00 0 0 000 0 0
20 0 0 c00 0 0 00 0 0 000 0 0
# blt: train lhp entry 2, only the blt counter selects it
01 1 0 000 1 1 08 0 0 080 1 0
01 1 0 000 1 1 08 0 0 080 1 0
01 1 0 000 1 1 08 0 0 080 1 0
01 1 0 000 1 1 08 0 0 080 1 0
01 1 0 000 1 1 08 0 0 080 1 0
08 0 0 080 0 0 00 0 0 000 1 1
08 0 0 fbf 0 0 00 0 0 000 1 1
08 0 0 0c0 0 0 00 0 0 000 0 0
08 0 0 a2a 0 0 00 0 0 000 0 0
08 1 0 080 0 0 00 0 0 000 1 0
# bge: equal stats split by trend, then by priority
04 1 0 000 1 0 04 1 0 000 1 0
04 1 0 000 1 0 04 1 0 000 1 0
04 1 0 000 1 0 04 1 0 000 1 0
04 1 0 000 1 0 04 1 0 000 1 0
04 1 0 000 0 0 00 0 0 000 0 2
04 1 1 000 0 0 00 0 0 000 0 1
04 1 1 010 0 0 00 0 0 000 1 0
04 0 0 000 0 0 00 0 0 000 0 0
# bgeu: lower sp entry 0 and raise lhp entry 2
01 0 0 002 1 1 01 0 0 002 0 0
01 0 0 002 1 1 01 0 0 002 0 0
01 0 0 002 1 1 01 0 0 002 0 0
# saturate sp entry 1, the last resolve ages the row
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 1 1 01 1 0 000 0 0
01 0 0 002 0 0 00 0 0 000 1 1
01 1 0 000 0 0 00 0 0 000 1 0
# stats already at 0 stay there
01 0 0 002 1 1 01 0 2 000 1 1
01 0 0 002 1 1 01 0 2 000 1 1
01 0 0 002 1 0 01 0 2 000 1 1
01 0 2 000 0 0 00 0 0 000 1 2
01 0 3 000 0 0 00 0 0 000 0 1
01 0 3 003 0 0 00 0 0 000 0 0

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
  --top-module meta_predictor_tb -o meta_predictor_sim &&
./obj_dir/meta_predictor_sim || exit 1

//--- source/bp_config_pkg.sv
package bp_config_pkg;

  // one row of entries per conditional branch type
  localparam int branch_types = 6;
  localparam int row_width = 3;

  // row addresses, beq on top
  localparam logic [row_width-1:0] beq_row  = 3'd5;
  localparam logic [row_width-1:0] bne_row  = 3'd4;
  localparam logic [row_width-1:0] blt_row  = 3'd3;
  localparam logic [row_width-1:0] bge_row  = 3'd2;
  localparam logic [row_width-1:0] bltu_row = 3'd1;
  localparam logic [row_width-1:0] bgeu_row = 3'd0;

  // 2-bit saturating counters of the local and global predictors
  localparam int hist_width = 2;
  localparam int hist_entries = 1 << hist_width;

  // accuracy count
  localparam int stat_width = 5;
  localparam int stat_max = (1 << stat_width) - 1;

  // low stat bits dropped when a row ages
  localparam int clear_bits = 3;

  // trend count, only used to break stat ties
  localparam int trend_width = 3;
  localparam int trend_max = (1 << trend_width) - 1;

  // static predictor starts ahead so it wins after reset
  localparam logic [stat_width-1:0] sp_stat_init = 5'd8;

endpackage

//--- source/bp_types_pkg.sv
package bp_types_pkg;

  typedef struct packed {
    logic [bp_config_pkg::trend_width-1:0] trend;
    logic [bp_config_pkg::stat_width-1:0]  stat;
  } entry_t;

  // lhp_counts is indexed by row, so element 5 belongs to beq
  typedef struct packed {
    logic [bp_config_pkg::branch_types-1:0]                                branch_type;
    logic                                                                  sp_taken;
    logic [bp_config_pkg::hist_width-1:0]                                  ghp_count;
    logic [bp_config_pkg::branch_types-1:0][bp_config_pkg::hist_width-1:0] lhp_counts;
  } lookup_t;

  // fields captured by the core when the branch was looked up
  typedef struct packed {
    logic                                                                  valid;
    logic                                                                  taken;
    logic [bp_config_pkg::branch_types-1:0]                                branch_type;
    logic                                                                  sp_taken;
    logic [bp_config_pkg::hist_width-1:0]                                  ghp_count;
    logic [bp_config_pkg::branch_types-1:0][bp_config_pkg::hist_width-1:0] lhp_counts;
  } resolve_t;

  typedef struct packed {
    logic [bp_config_pkg::row_width-1:0]  row;
    logic                                 sp_idx;
    logic [bp_config_pkg::hist_width-1:0] lhp_idx;
    logic [bp_config_pkg::hist_width-1:0] ghp_idx;
  } sel_t;

  typedef struct packed {
    entry_t sp;
    entry_t lhp;
    entry_t ghp;
  } trio_t;

  typedef struct packed {
    logic  en;
    logic  age;
    sel_t  sel;
    trio_t val;
  } write_t;

  typedef enum logic [1:0] {
    sp  = 2'd0,
    lhp = 2'd1,
    ghp = 2'd2
  } provider_t;

endpackage

//--- source/branch_row_select.sv
module branch_row_select (
  input  logic [bp_config_pkg::branch_types-1:0] branch_type,
  input  logic                                   sp_taken,
  input  logic [bp_config_pkg::hist_width-1:0]   ghp_count,
  input  logic [bp_config_pkg::branch_types-1:0][bp_config_pkg::hist_width-1:0] lhp_counts,
  output bp_types_pkg::sel_t                     sel
);

  logic [bp_config_pkg::row_width-1:0] row;

  // priority encode, beq first
  always_comb
  begin
    if (branch_type[5])
      row = bp_config_pkg::beq_row;
    else if (branch_type[4])
      row = bp_config_pkg::bne_row;
    else if (branch_type[3])
      row = bp_config_pkg::blt_row;
    else if (branch_type[2])
      row = bp_config_pkg::bge_row;
    else if (branch_type[1])
      row = bp_config_pkg::bltu_row;
    else
      row = bp_config_pkg::bgeu_row;
  end

  assign sel.row     = row;
  assign sel.sp_idx  = sp_taken;
  // only the counter of the looked-up type matters
  assign sel.lhp_idx = lhp_counts[row];
  assign sel.ghp_idx = ghp_count;

  // two types at once would make the encoder drop one silently
  always_comb
  begin
    if (!$isunknown(branch_type))
    begin
      assert ($onehot0(branch_type))
        else $error("branch_type has more than one bit set: %b", branch_type);
    end
  end

endmodule

//--- source/confidence_table.sv
module confidence_table (
  input  logic                  clk,
  input  logic                  rst_n,
  input  bp_types_pkg::sel_t    lookup_sel,
  input  bp_types_pkg::sel_t    resolve_sel,
  input  bp_types_pkg::write_t  wr,
  output bp_types_pkg::trio_t   lookup_entries,
  output bp_types_pkg::trio_t   resolve_entries
);

  bp_types_pkg::entry_t sp_tab  [bp_config_pkg::branch_types][2];
  bp_types_pkg::entry_t lhp_tab [bp_config_pkg::branch_types][bp_config_pkg::hist_entries];
  bp_types_pkg::entry_t ghp_tab [bp_config_pkg::branch_types][bp_config_pkg::hist_entries];

  bp_types_pkg::trio_t new_vals;

  // combinational read ports
  assign lookup_entries.sp   = sp_tab[lookup_sel.row][lookup_sel.sp_idx];
  assign lookup_entries.lhp  = lhp_tab[lookup_sel.row][lookup_sel.lhp_idx];
  assign lookup_entries.ghp  = ghp_tab[lookup_sel.row][lookup_sel.ghp_idx];

  assign resolve_entries.sp  = sp_tab[resolve_sel.row][resolve_sel.sp_idx];
  assign resolve_entries.lhp = lhp_tab[resolve_sel.row][resolve_sel.lhp_idx];
  assign resolve_entries.ghp = ghp_tab[resolve_sel.row][resolve_sel.ghp_idx];

  // an ageing row keeps only the upper stat bits of the new values
  always_comb
  begin
    new_vals = wr.val;
    if (wr.age)
    begin
      new_vals.sp.stat[bp_config_pkg::clear_bits-1:0]  = '0;
      new_vals.lhp.stat[bp_config_pkg::clear_bits-1:0] = '0;
      new_vals.ghp.stat[bp_config_pkg::clear_bits-1:0] = '0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int r = 0; r < bp_config_pkg::branch_types; r++)
      begin
        for (int i = 0; i < 2; i++)
        begin
          sp_tab[r][i].trend <= '0;
          sp_tab[r][i].stat  <= bp_config_pkg::sp_stat_init;
        end
        for (int i = 0; i < bp_config_pkg::hist_entries; i++)
        begin
          lhp_tab[r][i] <= '0;
          ghp_tab[r][i] <= '0;
        end
      end
    end
    else if (wr.en)
    begin
      if (wr.age)
      begin
        for (int i = 0; i < 2; i++)
        begin
          sp_tab[wr.sel.row][i].stat[bp_config_pkg::clear_bits-1:0] <= '0;
        end
        for (int i = 0; i < bp_config_pkg::hist_entries; i++)
        begin
          lhp_tab[wr.sel.row][i].stat[bp_config_pkg::clear_bits-1:0] <= '0;
          ghp_tab[wr.sel.row][i].stat[bp_config_pkg::clear_bits-1:0] <= '0;
        end
      end
      // selected entries override the row clear
      sp_tab[wr.sel.row][wr.sel.sp_idx]   <= new_vals.sp;
      lhp_tab[wr.sel.row][wr.sel.lhp_idx] <= new_vals.lhp;
      ghp_tab[wr.sel.row][wr.sel.ghp_idx] <= new_vals.ghp;
    end
  end

  // true when no entry of the row holds any low stat bit
  function automatic logic row_low_clear(logic [bp_config_pkg::row_width-1:0] r);
    logic ok;
    ok = 1'b1;
    for (int i = 0; i < 2; i++)
    begin
      if (sp_tab[r][i].stat[bp_config_pkg::clear_bits-1:0] != '0)
        ok = 1'b0;
    end
    for (int i = 0; i < bp_config_pkg::hist_entries; i++)
    begin
      if (lhp_tab[r][i].stat[bp_config_pkg::clear_bits-1:0] != '0 ||
          ghp_tab[r][i].stat[bp_config_pkg::clear_bits-1:0] != '0)
        ok = 1'b0;
    end
    return ok;
  endfunction

  // after ageing, selected and unselected entries of the row alike lose their low bits
  assert property (@(posedge clk) disable iff (!rst_n)
    wr.en && wr.age |=> row_low_clear($past(wr.sel.row)))
    else $error("aged row still holds low stat bits");

endmodule

//--- source/confidence_updater.sv
module confidence_updater (
  input  bp_types_pkg::resolve_t resolve,
  input  bp_types_pkg::sel_t     sel,
  input  bp_types_pkg::trio_t    entries,
  output bp_types_pkg::write_t   wr
);

  logic sp_right;
  logic lhp_right;
  logic ghp_right;
  logic sp_full;
  logic lhp_full;
  logic ghp_full;

  // saturating step of both counts
  function automatic bp_types_pkg::entry_t step(bp_types_pkg::entry_t e, logic right);
    bp_types_pkg::entry_t n;
    n = e;
    if (right)
    begin
      if (e.stat != bp_config_pkg::stat_max)
        n.stat = e.stat + 1'b1;
      if (e.trend != bp_config_pkg::trend_max)
        n.trend = e.trend + 1'b1;
    end
    else
    begin
      if (e.stat != '0)
        n.stat = e.stat - 1'b1;
      if (e.trend != '0)
        n.trend = e.trend - 1'b1;
    end
    return n;
  endfunction

  // counter direction is its top bit
  assign sp_right  = (resolve.sp_taken == resolve.taken);
  assign lhp_right = (sel.lhp_idx[bp_config_pkg::hist_width-1] == resolve.taken);
  assign ghp_right = (sel.ghp_idx[bp_config_pkg::hist_width-1] == resolve.taken);

  assign sp_full  = (entries.sp.stat == bp_config_pkg::stat_max);
  assign lhp_full = (entries.lhp.stat == bp_config_pkg::stat_max);
  assign ghp_full = (entries.ghp.stat == bp_config_pkg::stat_max);

  assign wr.en      = resolve.valid;
  // a right answer on a full stat would overflow, so the row ages
  assign wr.age     = (sp_right && sp_full) || (lhp_right && lhp_full) ||
                      (ghp_right && ghp_full);
  assign wr.sel     = sel;
  assign wr.val.sp  = step(entries.sp, sp_right);
  assign wr.val.lhp = step(entries.lhp, lhp_right);
  assign wr.val.ghp = step(entries.ghp, ghp_right);

endmodule

//--- source/meta_predictor.sv
module meta_predictor (
  input  logic                    clk,
  input  logic                    rst_n,
  input  bp_types_pkg::lookup_t   lookup,
  input  bp_types_pkg::resolve_t  resolve,
  output logic                    prediction,
  output bp_types_pkg::provider_t provider
);

  bp_types_pkg::sel_t   lookup_sel;
  bp_types_pkg::sel_t   resolve_sel;
  bp_types_pkg::trio_t  lookup_entries;
  bp_types_pkg::trio_t  resolve_entries;
  bp_types_pkg::write_t wr;

  branch_row_select u_lookup_sel (
    .branch_type (lookup.branch_type),
    .sp_taken    (lookup.sp_taken),
    .ghp_count   (lookup.ghp_count),
    .lhp_counts  (lookup.lhp_counts),
    .sel         (lookup_sel)
  );

  branch_row_select u_resolve_sel (
    .branch_type (resolve.branch_type),
    .sp_taken    (resolve.sp_taken),
    .ghp_count   (resolve.ghp_count),
    .lhp_counts  (resolve.lhp_counts),
    .sel         (resolve_sel)
  );

  confidence_table u_table (
    .clk             (clk),
    .rst_n           (rst_n),
    .lookup_sel      (lookup_sel),
    .resolve_sel     (resolve_sel),
    .wr              (wr),
    .lookup_entries  (lookup_entries),
    .resolve_entries (resolve_entries)
  );

  confidence_updater u_updater (
    .resolve (resolve),
    .sel     (resolve_sel),
    .entries (resolve_entries),
    .wr      (wr)
  );

  // directions are the top counter bits, lhp already picked per type
  source_arbiter u_arbiter (
    .entries    (lookup_entries),
    .sp_taken   (lookup.sp_taken),
    .lhp_taken  (lookup_sel.lhp_idx[bp_config_pkg::hist_width-1]),
    .ghp_taken  (lookup.ghp_count[bp_config_pkg::hist_width-1]),
    .prediction (prediction),
    .provider   (provider)
  );

endmodule

//--- source/source_arbiter.sv
module source_arbiter (
  input  bp_types_pkg::trio_t     entries,
  input  logic                    sp_taken,
  input  logic                    lhp_taken,
  input  logic                    ghp_taken,
  output logic                    prediction,
  output bp_types_pkg::provider_t provider
);

  bp_types_pkg::entry_t best;
  bp_types_pkg::provider_t pick;

  // strictly more trusted, trend only on equal stat
  function automatic logic beats(bp_types_pkg::entry_t a, bp_types_pkg::entry_t b);
    if (a.stat != b.stat)
      return a.stat > b.stat;
    return a.trend > b.trend;
  endfunction

  // start from ghp so full ties keep ghp, then lhp, then sp
  always_comb
  begin
    best = entries.ghp;
    pick = bp_types_pkg::ghp;
    if (beats(entries.lhp, best))
    begin
      best = entries.lhp;
      pick = bp_types_pkg::lhp;
    end
    if (beats(entries.sp, best))
    begin
      best = entries.sp;
      pick = bp_types_pkg::sp;
    end
  end

  assign provider = pick;

  always_comb
  begin
    case (pick)
      bp_types_pkg::lhp: prediction = lhp_taken;
      bp_types_pkg::ghp: prediction = ghp_taken;
      default:           prediction = sp_taken;
    endcase
  end

endmodule

//--- verilog.f
source/bp_config_pkg.sv
source/bp_types_pkg.sv
source/branch_row_select.sv
source/confidence_table.sv
source/confidence_updater.sv
source/source_arbiter.sv
source/meta_predictor.sv
bench/meta_predictor_tb.sv
